/* include/rsa_settings.svh */
`ifndef RSA_SETTINGS_SVH
`define RSA_SETTINGS_SVH

// Width of the modulus, the exponent and every operand in the datapath
`define RSA_WIDTH 256

// Byte addresses of the serial port registers
`define RSA_ADDR_RX     5'd0
`define RSA_ADDR_TX     5'd4
`define RSA_ADDR_STATUS 5'd8

// Flag positions in the status register
`define RSA_RX_OK_BIT 7
`define RSA_TX_OK_BIT 6

// Bytes per block received and sent
// Only the low 31 result bytes go back out
`define RSA_IN_BYTES  32
`define RSA_OUT_BYTES 31

`endif

/* rtl/rsa_pkg.sv */
`include "rsa_settings.svh"

package rsa_pkg;

    // One full-width operand of the modular arithmetic
    typedef logic [`RSA_WIDTH-1:0] rsa_word_t;

    // Exponent controller
    typedef enum logic [1:0] {
        core_idle,
        core_prescale,
        core_round,
        core_finish
    } core_state_e;

    // Bus master sequence of the top level
    typedef enum logic [2:0] {
        host_query_rx,
        host_get_key,
        host_get_data,
        host_wait_calc,
        host_query_tx,
        host_send_data
    } host_state_e;

endpackage

/* rtl/avm_pkg.sv */
`include "rsa_settings.svh"

package avm_pkg;

    typedef logic [4:0]  avm_addr_t;
    typedef logic [31:0] avm_data_t;

    // Status register view, flags placed at the positions of the register map
    typedef struct packed {
        logic [30-`RSA_RX_OK_BIT:0] rsvd_hi;
        logic                       rx_ok;
        logic                       tx_ok;
        logic [`RSA_TX_OK_BIT-1:0]  rsvd_lo;
    } avm_status_t;

    // Receive register view
    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  rx_byte;
    } avm_rx_t;

    // The same read word, taken apart by whichever register was addressed
    typedef union packed {
        avm_status_t status;
        avm_rx_t     rx;
    } avm_word_u;

endpackage

/* rtl/rsa_mont_mul.sv */
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_mont_mul (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t b,
    input  rsa_pkg::rsa_word_t n,
    output logic               done,
    output rsa_pkg::rsa_word_t result
);
    localparam int CNT_W = $clog2(`RSA_WIDTH);

    logic                  busy_r;
    logic [CNT_W-1:0]      step_r;
    logic                  last_step;
    rsa_pkg::rsa_word_t    a_sh_r;
    logic [`RSA_WIDTH:0]   acc_r;
    rsa_pkg::rsa_word_t    b_sel;
    logic [`RSA_WIDTH+1:0] sum_add;
    logic [`RSA_WIDTH+1:0] sum_odd;
    logic [`RSA_WIDTH:0]   acc_next;
    logic [`RSA_WIDTH:0]   acc_sub;

    assign last_step = step_r == CNT_W'(`RSA_WIDTH - 1);

    // The accumulator stays below 2n, so one spare bit holds it and two hold the sum
    always_comb begin
        b_sel    = a_sh_r[0] ? b : '0;
        sum_add  = {1'b0, acc_r} + {2'b00, b_sel};
        sum_odd  = sum_add[0] ? sum_add + {2'b00, n} : sum_add;
        acc_next = sum_odd[`RSA_WIDTH+1:1];
        acc_sub  = acc_next - {1'b0, n};
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy_r <= 1'b0;
            step_r <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_r <= 1'b1;
                step_r <= '0;
            end else if (busy_r) begin
                step_r <= step_r + 1'b1;
                if (last_step) begin
                    busy_r <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            a_sh_r <= a;
            acc_r  <= '0;
        end else if (busy_r) begin
            a_sh_r <= a_sh_r >> 1;
            acc_r  <= acc_next;
            // Final reduction folds into the last step
            if (last_step) begin
                result <= (acc_next >= {1'b0, n}) ? acc_sub[`RSA_WIDTH-1:0]
                                                  : acc_next[`RSA_WIDTH-1:0];
            end
        end
    end

endmodule

/* rtl/rsa_pre_scale.sv */
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_pre_scale (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t n,
    output logic               done,
    output rsa_pkg::rsa_word_t result
);
    localparam int CNT_W = $clog2(`RSA_WIDTH);

    logic                busy_r;
    logic [CNT_W-1:0]    step_r;
    rsa_pkg::rsa_word_t  val_r;
    logic [`RSA_WIDTH:0] dbl;
    logic [`RSA_WIDTH:0] dbl_sub;

    // One doubling per cycle, pulled back below n right away
    assign dbl     = {val_r, 1'b0};
    assign dbl_sub = dbl - {1'b0, n};
    assign result  = val_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy_r <= 1'b0;
            step_r <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_r <= 1'b1;
                step_r <= '0;
            end else if (busy_r) begin
                step_r <= step_r + 1'b1;
                if (step_r == CNT_W'(`RSA_WIDTH - 1)) begin
                    busy_r <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            val_r <= a;
        end else if (busy_r) begin
            val_r <= (dbl >= {1'b0, n}) ? dbl_sub[`RSA_WIDTH-1:0] : dbl[`RSA_WIDTH-1:0];
        end
    end

endmodule

/* rtl/rsa_modexp_core.sv */
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_modexp_core (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t d,
    input  rsa_pkg::rsa_word_t n,
    output logic               finished,
    output rsa_pkg::rsa_word_t result
);
    localparam int IDX_W = $clog2(`RSA_WIDTH);

    rsa_pkg::core_state_e state_r;
    logic [IDX_W-1:0]     bit_r;
    logic                 last_bit;
    logic                 pre_start;
    logic                 pre_done;
    rsa_pkg::rsa_word_t   pre_result;
    logic                 mul_start_r;
    logic                 sq_done;
    logic                 mu_done;
    logic                 both_done;
    rsa_pkg::rsa_word_t   sq_result;
    rsa_pkg::rsa_word_t   mu_result;
    rsa_pkg::rsa_word_t   base_r;
    rsa_pkg::rsa_word_t   acc_r;

    assign pre_start = start && (state_r == rsa_pkg::core_idle);
    assign both_done = sq_done & mu_done;
    assign last_bit  = bit_r == IDX_W'(`RSA_WIDTH - 1);
    assign finished  = state_r == rsa_pkg::core_finish;
    assign result    = acc_r;

    rsa_pre_scale u_pre (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (pre_start),
        .a       (a),
        .n       (n),
        .done    (pre_done),
        .result  (pre_result)
    );

    // Base squared, kept in the Montgomery domain
    rsa_mont_mul u_square (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mul_start_r),
        .a       (base_r),
        .b       (base_r),
        .n       (n),
        .done    (sq_done),
        .result  (sq_result)
    );

    // Plain accumulator times Montgomery base gives a plain product
    rsa_mont_mul u_mult (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mul_start_r),
        .a       (acc_r),
        .b       (base_r),
        .n       (n),
        .done    (mu_done),
        .result  (mu_result)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r     <= rsa_pkg::core_idle;
            bit_r       <= '0;
            mul_start_r <= 1'b0;
        end else begin
            mul_start_r <= 1'b0;
            case (state_r)
                rsa_pkg::core_idle: begin
                    if (start) begin
                        state_r <= rsa_pkg::core_prescale;
                    end
                end
                rsa_pkg::core_prescale: begin
                    if (pre_done) begin
                        bit_r       <= '0;
                        mul_start_r <= 1'b1;
                        state_r     <= rsa_pkg::core_round;
                    end
                end
                rsa_pkg::core_round: begin
                    if (both_done) begin
                        if (last_bit) begin
                            state_r <= rsa_pkg::core_finish;
                        end else begin
                            bit_r       <= bit_r + 1'b1;
                            mul_start_r <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_r <= rsa_pkg::core_idle;
                end
            endcase
        end
    end

    // Exponent bits are consumed from the least significant end
    always_ff @(posedge avm_clk) begin
        if (state_r == rsa_pkg::core_prescale && pre_done) begin
            base_r <= pre_result;
            acc_r  <= {{(`RSA_WIDTH-1){1'b0}}, 1'b1};
        end else if (state_r == rsa_pkg::core_round && both_done) begin
            base_r <= sq_result;
            if (d[bit_r]) begin
                acc_r <= mu_result;
            end
        end
    end

endmodule

/* rtl/rsa_avm_wrapper.sv */
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_avm_wrapper (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);
    localparam int KEY_BYTES = 2 * `RSA_IN_BYTES;
    localparam int CNT_W     = $clog2(KEY_BYTES);
    localparam int OUT_W     = 8 * `RSA_OUT_BYTES;

    rsa_pkg::host_state_e state_r;
    logic [CNT_W-1:0]     cnt_r;
    logic                 key_done_r;
    logic                 start_r;
    avm_pkg::avm_addr_t   address_r;
    logic                 read_r;
    logic                 write_r;
    avm_pkg::avm_data_t   writedata_r;

    rsa_pkg::rsa_word_t   n_r;
    rsa_pkg::rsa_word_t   d_r;
    rsa_pkg::rsa_word_t   enc_r;
    logic [OUT_W-1:0]     dec_r;

    avm_pkg::avm_word_u   rd_word;
    logic                 rd_done;
    logic                 wr_done;
    logic                 tx_grant;
    logic                 last_key;
    logic                 last_data;
    logic                 last_out;
    logic                 core_finished;
    rsa_pkg::rsa_word_t   core_result;

    assign avm_address   = address_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = writedata_r;

    assign rd_word   = avm_readdata;
    assign rd_done   = read_r & ~avm_waitrequest;
    assign wr_done   = write_r & ~avm_waitrequest;
    assign tx_grant  = (state_r == rsa_pkg::host_query_tx) && rd_done && rd_word.status.tx_ok;
    assign last_key  = cnt_r == CNT_W'(KEY_BYTES - 1);
    assign last_data = cnt_r == CNT_W'(`RSA_IN_BYTES - 1);
    assign last_out  = cnt_r == CNT_W'(`RSA_OUT_BYTES - 1);

    rsa_modexp_core u_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start_r),
        .a        (enc_r),
        .d        (d_r),
        .n        (n_r),
        .finished (core_finished),
        .result   (core_result)
    );

    // Bus requests change only after a completed transfer
    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r     <= rsa_pkg::host_query_rx;
            cnt_r       <= '0;
            key_done_r  <= 1'b0;
            start_r     <= 1'b0;
            address_r   <= `RSA_ADDR_STATUS;
            read_r      <= 1'b1;
            write_r     <= 1'b0;
            writedata_r <= '0;
        end else begin
            start_r <= 1'b0;
            case (state_r)
                rsa_pkg::host_query_rx: begin
                    if (rd_done && rd_word.status.rx_ok) begin
                        address_r <= `RSA_ADDR_RX;
                        state_r   <= key_done_r ? rsa_pkg::host_get_data : rsa_pkg::host_get_key;
                    end
                end
                rsa_pkg::host_get_key: begin
                    if (rd_done) begin
                        address_r <= `RSA_ADDR_STATUS;
                        state_r   <= rsa_pkg::host_query_rx;
                        if (last_key) begin
                            cnt_r      <= '0;
                            key_done_r <= 1'b1;
                        end else begin
                            cnt_r <= cnt_r + 1'b1;
                        end
                    end
                end
                rsa_pkg::host_get_data: begin
                    if (rd_done) begin
                        if (last_data) begin
                            cnt_r   <= '0;
                            read_r  <= 1'b0;
                            start_r <= 1'b1;
                            state_r <= rsa_pkg::host_wait_calc;
                        end else begin
                            cnt_r     <= cnt_r + 1'b1;
                            address_r <= `RSA_ADDR_STATUS;
                            state_r   <= rsa_pkg::host_query_rx;
                        end
                    end
                end
                rsa_pkg::host_wait_calc: begin
                    if (core_finished) begin
                        read_r    <= 1'b1;
                        address_r <= `RSA_ADDR_STATUS;
                        state_r   <= rsa_pkg::host_query_tx;
                    end
                end
                rsa_pkg::host_query_tx: begin
                    if (tx_grant) begin
                        read_r      <= 1'b0;
                        write_r     <= 1'b1;
                        address_r   <= `RSA_ADDR_TX;
                        writedata_r <= {24'd0, dec_r[OUT_W-1 -: 8]};
                        state_r     <= rsa_pkg::host_send_data;
                    end
                end
                rsa_pkg::host_send_data: begin
                    if (wr_done) begin
                        write_r   <= 1'b0;
                        read_r    <= 1'b1;
                        address_r <= `RSA_ADDR_STATUS;
                        if (last_out) begin
                            cnt_r   <= '0;
                            state_r <= rsa_pkg::host_query_rx;
                        end else begin
                            cnt_r   <= cnt_r + 1'b1;
                            state_r <= rsa_pkg::host_query_tx;
                        end
                    end
                end
                default: begin
                    state_r <= rsa_pkg::host_query_rx;
                end
            endcase
        end
    end

    // Key and data arrive most significant byte first
    always_ff @(posedge avm_clk) begin
        if (rd_done && state_r == rsa_pkg::host_get_key) begin
            if (cnt_r < CNT_W'(`RSA_IN_BYTES)) begin
                n_r <= {n_r[`RSA_WIDTH-9:0], rd_word.rx.rx_byte};
            end else begin
                d_r <= {d_r[`RSA_WIDTH-9:0], rd_word.rx.rx_byte};
            end
        end
        if (rd_done && state_r == rsa_pkg::host_get_data) begin
            enc_r <= {enc_r[`RSA_WIDTH-9:0], rd_word.rx.rx_byte};
        end
        if (state_r == rsa_pkg::host_wait_calc && core_finished) begin
            dec_r <= core_result[OUT_W-1:0];
        end else if (tx_grant) begin
            dec_r <= {dec_r[OUT_W-9:0], 8'd0};
        end
    end

endmodule

/* dv/rsa_avm_asserts.sv */
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_avm_asserts (
    input logic        avm_clk,
    input logic        avm_rst,
    input logic [4:0]  avm_address,
    input logic        avm_read,
    input logic        avm_write,
    input logic [31:0] avm_writedata,
    input logic        avm_waitrequest
);
    // Number of failed assertions so far
    int err_count = 0;

    property no_read_and_write;
        @(posedge avm_clk) disable iff (avm_rst)
            !(avm_read && avm_write);
    endproperty

    // A stalled request keeps every master output unchanged
    property hold_on_wait;
        @(posedge avm_clk) disable iff (avm_rst)
            (avm_read || avm_write) && avm_waitrequest |=>
                $stable(avm_address) && $stable(avm_read) &&
                $stable(avm_write) && $stable(avm_writedata);
    endproperty

    property write_to_tx_only;
        @(posedge avm_clk) disable iff (avm_rst)
            avm_write |-> avm_address == `RSA_ADDR_TX;
    endproperty

    a_no_read_and_write: assert property (no_read_and_write)
        else begin
            $error("read and write are high together");
            err_count++;
        end

    a_hold_on_wait: assert property (hold_on_wait)
        else begin
            $error("request changed while waitrequest was high");
            err_count++;
        end

    a_write_to_tx_only: assert property (write_to_tx_only)
        else begin
            $error("write to an address other than tx");
            err_count++;
        end

endmodule

bind rsa_avm_wrapper rsa_avm_asserts u_asserts (
    .avm_clk         (avm_clk),
    .avm_rst         (avm_rst),
    .avm_address     (avm_address),
    .avm_read        (avm_read),
    .avm_write       (avm_write),
    .avm_writedata   (avm_writedata),
    .avm_waitrequest (avm_waitrequest)
);

/* dv/rsa_tb.sv */
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_tb;
    localparam int NUM_BLOCKS    = 3;
    localparam int BLOCK_TIMEOUT = 100000;
    localparam int SETTLE_CYCLES = 2000;
    localparam int OUT_W         = 8 * `RSA_OUT_BYTES;

    logic        avm_clk         = 1'b0;
    logic        avm_rst         = 1'b1;
    logic [31:0] avm_readdata    = '0;
    logic        avm_waitrequest = 1'b1;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic        avm_write;
    logic [31:0] avm_writedata;

    logic [31:0]      rng_state = 32'd4;
    logic [7:0]       rx_q[$];
    logic [7:0]       tx_q[$];
    logic [OUT_W-1:0] exp_q[$];
    logic             rx_armed  = 1'b0;
    logic             tx_armed  = 1'b0;

    always #50 avm_clk = ~avm_clk;

    rsa_avm_wrapper dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic rsa_pkg::rsa_word_t random_operand();
        rsa_pkg::rsa_word_t w;
        int i;
        for (i = 0; i < `RSA_WIDTH / 32; i++) begin
            w[32*i +: 32] = next_random();
        end
        return w;
    endfunction

    // Square-and-multiply on double-width values with the exponent scanned from bit 0 up
    function automatic rsa_pkg::rsa_word_t ref_modexp(input rsa_pkg::rsa_word_t base,
                                                      input rsa_pkg::rsa_word_t exponent,
                                                      input rsa_pkg::rsa_word_t modulus);
        logic [2*`RSA_WIDTH-1:0] acc;
        logic [2*`RSA_WIDTH-1:0] sq;
        logic [2*`RSA_WIDTH-1:0] m;
        int i;
        m   = {{`RSA_WIDTH{1'b0}}, modulus};
        acc = 1;
        sq  = {{`RSA_WIDTH{1'b0}}, base} % m;
        for (i = 0; i < `RSA_WIDTH; i++) begin
            if (exponent[i]) begin
                acc = (acc * sq) % m;
            end
            sq = (sq * sq) % m;
        end
        return acc[`RSA_WIDTH-1:0];
    endfunction

    task automatic check_value(input string name, input rsa_pkg::rsa_word_t expected,
                               input rsa_pkg::rsa_word_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic queue_block(input rsa_pkg::rsa_word_t w);
        int i;
        for (i = `RSA_IN_BYTES - 1; i >= 0; i--) begin
            rx_q.push_back(w[8*i +: 8]);
        end
    endtask

    // Serial port model where a transfer completes on each edge that sees waitrequest low
    always @(posedge avm_clk) begin : bus_slave
        logic [31:0]        rnd;
        avm_pkg::avm_word_u word;
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
        end else if (!avm_waitrequest) begin
            word = avm_readdata;
            avm_waitrequest <= 1'b1;
            if (avm_read && avm_address == `RSA_ADDR_STATUS) begin
                rx_armed = word.status.rx_ok;
                tx_armed = word.status.tx_ok;
            end else if (avm_read) begin
                check_value("rx read after ready status", 1, rsa_pkg::rsa_word_t'(rx_armed));
                void'(rx_q.pop_front());
                rx_armed = 1'b0;
                tx_armed = 1'b0;
            end else begin
                check_value("tx write after ready status", 1, rsa_pkg::rsa_word_t'(tx_armed));
                tx_q.push_back(avm_writedata[7:0]);
                rx_armed = 1'b0;
                tx_armed = 1'b0;
            end
        end else if (avm_read || avm_write) begin
            rnd = next_random();
            if (rnd[1:0] != 2'b00) begin
                // Reserved bits stay random so the decode is exercised
                word = rnd;
                if (avm_address == `RSA_ADDR_STATUS) begin
                    word.status.rx_ok = rx_q.size() != 0 && rnd[9:8] != 2'b00;
                    word.status.tx_ok = rnd[11:10] != 2'b00;
                end else begin
                    word.rx.rx_byte = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
                end
                avm_readdata    <= word;
                avm_waitrequest <= 1'b0;
            end
        end
    end

    always @(negedge avm_clk) begin
        if (dut.u_asserts.err_count != 0) begin
            check_value("bus protocol assertions", 0,
                        rsa_pkg::rsa_word_t'(dut.u_asserts.err_count));
        end
    end

    initial begin : stimulus
        rsa_pkg::rsa_word_t key_n;
        rsa_pkg::rsa_word_t key_d;
        rsa_pkg::rsa_word_t cipher;
        rsa_pkg::rsa_word_t plain;
        int blk;
        repeat (4) @(posedge avm_clk);
        avm_rst <= 1'b0;
        @(negedge avm_clk);
        check_value("reset read", 1, rsa_pkg::rsa_word_t'(avm_read));
        check_value("reset write", 0, rsa_pkg::rsa_word_t'(avm_write));
        check_value("reset address", `RSA_ADDR_STATUS, rsa_pkg::rsa_word_t'(avm_address));
        // Odd modulus with the top bit set
        key_n = random_operand();
        key_n[`RSA_WIDTH-1] = 1'b1;
        key_n[0] = 1'b1;
        key_d = random_operand();
        queue_block(key_n);
        queue_block(key_d);
        for (blk = 0; blk < NUM_BLOCKS; blk++) begin
            cipher = random_operand() % key_n;
            plain  = ref_modexp(cipher, key_d, key_n);
            queue_block(cipher);
            exp_q.push_back(plain[OUT_W-1:0]);
        end
    end

    initial begin : compare
        logic [OUT_W-1:0] got;
        logic [OUT_W-1:0] expected;
        int blk;
        int cyc;
        int i;
        for (blk = 0; blk < NUM_BLOCKS; blk++) begin
            cyc = 0;
            while (tx_q.size() < `RSA_OUT_BYTES || exp_q.size() == 0) begin
                @(negedge avm_clk);
                cyc++;
                if (cyc > BLOCK_TIMEOUT) begin
                    $display("Timed out waiting for the result bytes of block %0d", blk);
                    $display("TEST FAILED");
                    $fatal(1);
                end
            end
            got = '0;
            for (i = 0; i < `RSA_OUT_BYTES; i++) begin
                got = {got[OUT_W-9:0], tx_q.pop_front()};
            end
            expected = exp_q.pop_front();
            check_value($sformatf("block %0d result", blk), rsa_pkg::rsa_word_t'(expected),
                        rsa_pkg::rsa_word_t'(got));
            // A block that is written out too long shows up during this quiet period
            repeat (SETTLE_CYCLES) @(negedge avm_clk);
            check_value($sformatf("block %0d extra bytes", blk), 0,
                        rsa_pkg::rsa_word_t'(tx_q.size()));
        end
        if (dut.u_asserts.err_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("A bus protocol assertion failed during the run");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

/* build.f */
+incdir+include
rtl/rsa_pkg.sv
rtl/avm_pkg.sv
rtl/rsa_mont_mul.sv
rtl/rsa_pre_scale.sv
rtl/rsa_modexp_core.sv
rtl/rsa_avm_wrapper.sv
dv/rsa_avm_asserts.sv
dv/rsa_tb.sv

/* Bender.yml */
package:
  name: rsa_avm

sources:
  - include_dirs:
      - include
    files:
      - rtl/rsa_pkg.sv
      - rtl/avm_pkg.sv
      - rtl/rsa_mont_mul.sv
      - rtl/rsa_pre_scale.sv
      - rtl/rsa_modexp_core.sv
      - rtl/rsa_avm_wrapper.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/rsa_avm_asserts.sv
      - dv/rsa_tb.sv
